// ==== list.f ====
+incdir+logic
logic/lenet_pkg.sv
logic/layer_sequencer.sv
logic/layer_counter.sv
logic/dense_engine.sv
logic/sram_port_regs.sv
logic/lenet.sv
testbench/tb_clock.sv
testbench/lenet_sva.sv
testbench/tb_lenet.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tb_lenet
FILELIST  := list.f
OBJDIR    := obj_dir
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/tb_lenet.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module tb_lenet;
    localparam int RESET_TIMEOUT  = 100;
    localparam int FINISH_TIMEOUT = 10000;
    localparam int FC6_IN  = `LENET_FC6_IN;
    localparam int FC6_OUT = `LENET_FC6_OUT;
    localparam int FC7_OUT = `LENET_FC7_OUT;
    localparam int FC6_LO  = `LENET_A_FC6_BASE;
    localparam int FC6_HI  = `LENET_A_FC6_BASE + (`LENET_FC6_OUT + 3) / 4;
    localparam int FC7_LO  = `LENET_A_FC7_BASE;
    localparam int FC7_HI  = `LENET_A_FC7_BASE + (`LENET_FC7_OUT + 3) / 4;

    logic                  clk;
    logic                  rst_n;
    logic                  compute_start = 1'b0;
    logic                  compute_finish;
    lenet_pkg::scale_t     scale_fc6 = 32'd128;
    lenet_pkg::scale_t     scale_fc7 = 32'd384;
    lenet_pkg::sram_port_t weight_port;
    lenet_pkg::sram_port_t act_port;
    lenet_pkg::sram_word_t weight_rdata = '0;
    lenet_pkg::sram_word_t act_rdata = '0;

    lenet_pkg::sram_word_t wmem [4096];
    lenet_pkg::sram_word_t amem [128];
    int     ref_fc6 [FC6_OUT];
    int     ref_fc7 [FC7_OUT];
    integer seed;
    int     test_errors;
    int     errors;
    int     tests_run;
    int     failed_tests;
    int     wea_errors;
    int     region_errors;

    tb_clock u_clk (
        .clk  (clk),
        .rst_n(rst_n)
    );

    lenet u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .compute_start (compute_start),
        .compute_finish(compute_finish),
        .scale_fc6     (scale_fc6),
        .scale_fc7     (scale_fc7),
        .weight_port   (weight_port),
        .act_port      (act_port),
        .weight_rdata  (weight_rdata),
        .act_rdata     (act_rdata)
    );

    // Weight SRAM with one cycle of read latency
    always @(posedge clk) begin
        weight_rdata <= wmem[weight_port.addr[11:0]];
    end

    // Activation SRAM with byte enables
    always @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (act_port.wea[k]) begin
                amem[act_port.addr[6:0]][8*k +: 8] <= act_port.wdata[8*k +: 8];
            end
        end
        act_rdata <= amem[act_port.addr[6:0]];
    end

    function automatic bit in_out_region(lenet_pkg::sram_addr_t a);
        return (int'(a) >= FC6_LO && int'(a) < FC6_HI) || (int'(a) >= FC7_LO && int'(a) < FC7_HI);
    endfunction

    // Port monitor sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (weight_port.wea == '0) else begin
                $display("Fail weight_port.wea: expected 0x0, got 0x%h", weight_port.wea);
                wea_errors++;
            end
            assert ($onehot0(act_port.wea)) else begin
                $display("Fail act_port.wea: expected zero or one-hot, got 0x%h", act_port.wea);
                wea_errors++;
            end
            if (act_port.wea != '0) begin
                assert (in_out_region(act_port.addr)) else begin
                    $display("Fail act_port.addr: outside output regions, got 0x%h",
                             act_port.addr);
                    region_errors++;
                end
            end
        end
    end

    function automatic int sbyte(lenet_pkg::sram_word_t w, int k);
        return int'(lenet_pkg::act_t'(w[8*k +: 8]));
    endfunction

    // Scale multiply, arithmetic shift, then ReLU and clamp to 127
    function automatic int requant(longint acc, lenet_pkg::scale_t scale);
        longint v;
        v = (acc * longint'(scale)) >>> `LENET_RQ_SHIFT;
        if (v < 0) begin
            return 0;
        end
        if (v > 127) begin
            return 127;
        end
        return int'(v);
    endfunction

    task automatic build_reference();
        longint acc;
        int     wb;
        for (int o = 0; o < FC6_OUT; o++) begin
            acc = 0;
            for (int i = 0; i < FC6_IN; i++) begin
                wb = `LENET_W_FC6_BASE * 4 + o * FC6_IN + i;
                acc += sbyte(wmem[wb / 4], wb % 4) * sbyte(amem[`LENET_A_IN_BASE + i / 4], i % 4);
            end
            ref_fc6[o] = requant(acc, scale_fc6);
        end
        // FC7 runs on the reference FC6 outputs
        for (int o = 0; o < FC7_OUT; o++) begin
            acc = 0;
            for (int i = 0; i < FC6_OUT; i++) begin
                wb = `LENET_W_FC7_BASE * 4 + o * FC6_OUT + i;
                acc += sbyte(wmem[wb / 4], wb % 4) * ref_fc6[i];
            end
            ref_fc7[o] = requant(acc, scale_fc7);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(string name, logic [31:0] exp, logic [31:0] got);
        assert (exp === got) else begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, got);
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
            failed_tests++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        int n;
        int zeros;
        int tops;
        test_errors = 0;
        errors = 0;
        tests_run = 0;
        failed_tests = 0;
        wea_errors = 0;
        region_errors = 0;
        seed = 83683;
        for (int a = 0; a < 4096; a++) begin
            wmem[a] = $random(seed);
        end
        for (int a = 0; a < 128; a++) begin
            amem[a] <= $random(seed);
        end

        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            step();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            test_errors++;
        end
        build_reference();

        for (int c = 0; c < 50; c++) begin
            step();
            compare_value("compute_finish", 32'(0), 32'(compute_finish));
            compare_value("weight_port.wea", 32'(0), 32'(weight_port.wea));
            compare_value("act_port.wea", 32'(0), 32'(act_port.wea));
        end
        finish_test("idle without start");

        compute_start = 1'b1;
        step();
        compute_start = 1'b0;
        n = 0;
        while (compute_finish !== 1'b1 && n < FINISH_TIMEOUT) begin
            step();
            n++;
        end
        if (compute_finish !== 1'b1) begin
            $display("Timeout: compute_finish did not rise within %0d cycles", FINISH_TIMEOUT);
            test_errors++;
        end
        // Also lets the last result write reach the SRAM
        for (int c = 0; c < 20; c++) begin
            step();
            compare_value("compute_finish", 32'(1), 32'(compute_finish));
        end
        finish_test("compute_finish rises and holds");

        for (int o = 0; o < FC6_OUT; o++) begin
            compare_value($sformatf("act SRAM word %0d byte %0d", FC6_LO + o / 4, o % 4),
                          32'(ref_fc6[o]), 32'(amem[FC6_LO + o / 4][8*(o%4) +: 8]));
        end
        finish_test("FC6 outputs");

        zeros = 0;
        tops = 0;
        for (int o = 0; o < FC7_OUT; o++) begin
            compare_value($sformatf("act SRAM word %0d byte %0d", FC7_LO + o / 4, o % 4),
                          32'(ref_fc7[o]), 32'(amem[FC7_LO + o / 4][8*(o%4) +: 8]));
            zeros += (ref_fc7[o] == 0) ? 1 : 0;
            tops += (ref_fc7[o] == 127) ? 1 : 0;
        end
        // Both clamp limits must be exercised by the FC7 data
        if (zeros == 0 || tops == 0) begin
            $display("FC7 data misses a clamp limit with %0d outputs at 0 and %0d at 127",
                     zeros, tops);
            test_errors++;
        end
        finish_test("FC7 outputs");

        test_errors += wea_errors;
        finish_test("write enables");
        test_errors += region_errors;
        finish_test("write address regions");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== testbench/lenet_sva.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module lenet_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  compute_finish,
    input lenet_pkg::sram_port_t weight_port,
    input lenet_pkg::sram_port_t act_port
);
    localparam int FC6_LO = `LENET_A_FC6_BASE;
    localparam int FC6_HI = `LENET_A_FC6_BASE + (`LENET_FC6_OUT + 3) / 4;
    localparam int FC7_LO = `LENET_A_FC7_BASE;
    localparam int FC7_HI = `LENET_A_FC7_BASE + (`LENET_FC7_OUT + 3) / 4;

    logic wr_in_region;

    assign wr_in_region = (int'(act_port.addr) >= FC6_LO && int'(act_port.addr) < FC6_HI) ||
                          (int'(act_port.addr) >= FC7_LO && int'(act_port.addr) < FC7_HI);

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> (!compute_finish && weight_port.wea == '0 && act_port.wea == '0))
        else $error("outputs not cleared by reset");

    finish_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        compute_finish |=> compute_finish)
        else $error("compute_finish dropped after rising");

    weight_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        weight_port.wea == '0)
        else $error("weight SRAM written");

    act_wea_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(act_port.wea))
        else $error("act_port.wea has more than one byte set");

    act_wr_region: assert property (@(posedge clk) disable iff (!rst_n)
        (act_port.wea != '0) |-> wr_in_region)
        else $error("act write outside the FC6 and FC7 output regions");

endmodule

bind lenet lenet_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .compute_finish(compute_finish),
    .weight_port   (weight_port),
    .act_port      (act_port)
);

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for ten rising edges, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== logic/lenet.sv ====
`timescale 1ns/1ps

module lenet (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  compute_start,
    output logic                  compute_finish,
    input  lenet_pkg::scale_t     scale_fc6,
    input  lenet_pkg::scale_t     scale_fc7,
    output lenet_pkg::sram_port_t weight_port,
    output lenet_pkg::sram_port_t act_port,
    input  lenet_pkg::sram_word_t weight_rdata,
    input  lenet_pkg::sram_word_t act_rdata
);
    lenet_pkg::layer_t     layer;
    logic                  layer_start;
    logic                  layer_done;
    lenet_pkg::sram_port_t act_wr;
    lenet_pkg::sram_addr_t w_addr;
    lenet_pkg::sram_addr_t a_addr;
    lenet_pkg::sram_word_t w_word;
    lenet_pkg::sram_word_t a_word;
    lenet_pkg::scale_t     scale_sel;
    logic                  rd_valid;
    logic                  rd_first;
    logic                  rd_last;
    logic [6:0]            out_idx;

    sram_port_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .layer          (layer),
        .act_wr         (act_wr),
        .w_addr         (w_addr),
        .a_addr         (a_addr),
        .scale_fc6_in   (scale_fc6),
        .scale_fc7_in   (scale_fc7),
        .weight_rdata_in(weight_rdata),
        .act_rdata_in   (act_rdata),
        .weight_port    (weight_port),
        .act_port       (act_port),
        .w_word         (w_word),
        .a_word         (a_word),
        .scale          (scale_sel)
    );

    layer_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .compute_start (compute_start),
        .layer_done    (layer_done),
        .layer_start   (layer_start),
        .layer         (layer),
        .compute_finish(compute_finish)
    );

    layer_counter u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .layer_start(layer_start),
        .layer      (layer),
        .w_addr     (w_addr),
        .a_addr     (a_addr),
        .rd_valid   (rd_valid),
        .rd_first   (rd_first),
        .rd_last    (rd_last),
        .out_idx    (out_idx)
    );

    dense_engine u_eng (
        .clk       (clk),
        .rst_n     (rst_n),
        .layer     (layer),
        .scale     (scale_sel),
        .w_word    (w_word),
        .a_word    (a_word),
        .rd_valid  (rd_valid),
        .rd_first  (rd_first),
        .rd_last   (rd_last),
        .out_idx   (out_idx),
        .act_wr    (act_wr),
        .layer_done(layer_done)
    );

endmodule

// ==== logic/sram_port_regs.sv ====
`timescale 1ns/1ps

module sram_port_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lenet_pkg::layer_t     layer,
    input  lenet_pkg::sram_port_t act_wr,
    input  lenet_pkg::sram_addr_t w_addr,
    input  lenet_pkg::sram_addr_t a_addr,
    input  lenet_pkg::scale_t     scale_fc6_in,
    input  lenet_pkg::scale_t     scale_fc7_in,
    input  lenet_pkg::sram_word_t weight_rdata_in,
    input  lenet_pkg::sram_word_t act_rdata_in,
    output lenet_pkg::sram_port_t weight_port,
    output lenet_pkg::sram_port_t act_port,
    output lenet_pkg::sram_word_t w_word,
    output lenet_pkg::sram_word_t a_word,
    output lenet_pkg::scale_t     scale
);
    lenet_pkg::scale_t sc_fc6;
    lenet_pkg::scale_t sc_fc7;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            weight_port <= '0;
            act_port    <= '0;
            w_word      <= '0;
            a_word      <= '0;
            sc_fc6      <= '0;
            sc_fc7      <= '0;
        end else begin
            // Weights are read only
            weight_port <= '{wea: '0, addr: w_addr, wdata: '0};
            if (act_wr.wea != '0) begin
                act_port <= act_wr;
            end else begin
                act_port <= '{wea: '0, addr: a_addr, wdata: '0};
            end
            w_word <= weight_rdata_in;
            a_word <= act_rdata_in;
            sc_fc6 <= scale_fc6_in;
            sc_fc7 <= scale_fc7_in;
        end
    end

    assign scale = (layer == lenet_pkg::fc6) ? sc_fc6 : sc_fc7;

endmodule

// ==== logic/dense_engine.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module dense_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lenet_pkg::layer_t     layer,
    input  lenet_pkg::scale_t     scale,
    input  lenet_pkg::sram_word_t w_word,
    input  lenet_pkg::sram_word_t a_word,
    input  logic                  rd_valid,
    input  logic                  rd_first,
    input  logic                  rd_last,
    input  logic [6:0]            out_idx,
    output lenet_pkg::sram_port_t act_wr,
    output logic                  layer_done
);
    // A result write takes the act port while word 3 of the next output is read
    localparam int STEAL_POS = 3;

    logic [2:0]            valid_sr;
    logic [2:0]            first_sr;
    logic [2:0]            last_sr;
    logic [2:0]            stolen_sr;
    logic [6:0]            idx_sr [3];
    logic [4:0]            pos;
    logic [4:0]            cur_pos;
    lenet_pkg::sram_word_t a_hold;
    lenet_pkg::sram_word_t a_eff;
    lenet_pkg::acc_t       acc;
    lenet_pkg::acc_t       dot;
    logic                  wr_pend;
    logic [6:0]            wr_idx;
    logic signed [64:0]    prod;
    logic signed [64:0]    shifted;
    lenet_pkg::act_t       q;
    lenet_pkg::sram_addr_t out_base;
    logic [6:0]            last_out;

    // Tags wait out the address register, SRAM and rdata register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr  <= '0;
            first_sr  <= '0;
            last_sr   <= '0;
            stolen_sr <= '0;
        end else begin
            valid_sr  <= {valid_sr[1:0], rd_valid};
            first_sr  <= {first_sr[1:0], rd_first};
            last_sr   <= {last_sr[1:0], rd_last};
            stolen_sr <= {stolen_sr[1:0], wr_pend};
        end
        idx_sr[0] <= out_idx;
        idx_sr[1] <= idx_sr[0];
        idx_sr[2] <= idx_sr[1];
    end

    // Lost word is replayed since every output reads the same activation vector
    assign cur_pos = first_sr[2] ? 5'd0 : pos;
    assign a_eff   = stolen_sr[2] ? a_hold : a_word;

    always_comb begin
        dot = '0;
        for (int k = 0; k < 4; k++) begin
            dot = dot + lenet_pkg::acc_t'(lenet_pkg::act_t'(w_word[8*k +: 8])) *
                        lenet_pkg::acc_t'(lenet_pkg::act_t'(a_eff[8*k +: 8]));
        end
    end

    always_ff @(posedge clk) begin
        if (valid_sr[2]) begin
            acc <= (first_sr[2] ? lenet_pkg::acc_t'(0) : acc) + dot;
            pos <= cur_pos + 5'd1;
            if (cur_pos == 5'(STEAL_POS) && !stolen_sr[2]) begin
                a_hold <= a_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= valid_sr[2] && last_sr[2];
        end
        if (valid_sr[2] && last_sr[2]) begin
            wr_idx <= idx_sr[2];
        end
    end

    // Requantize, then ReLU and saturate
    always_comb begin
        prod    = $signed(acc) * $signed({1'b0, scale});
        shifted = prod >>> `LENET_RQ_SHIFT;
        if (shifted < 0) begin
            q = '0;
        end else if (shifted > 127) begin
            q = 8'sd127;
        end else begin
            q = lenet_pkg::act_t'(shifted[7:0]);
        end
    end

    assign out_base = (layer == lenet_pkg::fc6) ? lenet_pkg::sram_addr_t'(`LENET_A_FC6_BASE)
                                                : lenet_pkg::sram_addr_t'(`LENET_A_FC7_BASE);
    assign last_out = (layer == lenet_pkg::fc6) ? 7'(`LENET_FC6_OUT - 1)
                                                : 7'(`LENET_FC7_OUT - 1);

    assign act_wr.wea   = wr_pend ? lenet_pkg::byte_en_t'(4'b0001 << wr_idx[1:0]) : '0;
    assign act_wr.addr  = out_base + lenet_pkg::sram_addr_t'(wr_idx[6:2]);
    assign act_wr.wdata = {4{q}};
    assign layer_done   = wr_pend && (wr_idx == last_out);

endmodule

// ==== logic/layer_counter.sv ====
`timescale 1ns/1ps
`include "lenet_consts.svh"

module layer_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  layer_start,
    input  lenet_pkg::layer_t     layer,
    output lenet_pkg::sram_addr_t w_addr,
    output lenet_pkg::sram_addr_t a_addr,
    output logic                  rd_valid,
    output logic                  rd_first,
    output logic                  rd_last,
    output logic [6:0]            out_idx
);
    logic                  busy;
    logic [4:0]            word;
    logic [6:0]            out_cnt;
    lenet_pkg::sram_addr_t w_ptr;
    logic [4:0]            n_words;
    logic [6:0]            last_out;
    lenet_pkg::sram_addr_t w_base;
    lenet_pkg::sram_addr_t a_base;
    logic                  last_word;

    // FC7 reads the FC6 outputs as its input vector
    always_comb begin
        if (layer == lenet_pkg::fc6) begin
            n_words  = 5'(`LENET_FC6_IN / 4);
            last_out = 7'(`LENET_FC6_OUT - 1);
            w_base   = lenet_pkg::sram_addr_t'(`LENET_W_FC6_BASE);
            a_base   = lenet_pkg::sram_addr_t'(`LENET_A_IN_BASE);
        end else begin
            n_words  = 5'(`LENET_FC6_OUT / 4);
            last_out = 7'(`LENET_FC7_OUT - 1);
            w_base   = lenet_pkg::sram_addr_t'(`LENET_W_FC7_BASE);
            a_base   = lenet_pkg::sram_addr_t'(`LENET_A_FC6_BASE);
        end
    end

    assign last_word = (word == n_words - 5'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            word    <= '0;
            out_cnt <= '0;
            w_ptr   <= '0;
        end else if (layer_start) begin
            busy    <= 1'b1;
            word    <= '0;
            out_cnt <= '0;
            w_ptr   <= w_base;
        end else if (busy) begin
            // Row-major weights are contiguous across outputs
            w_ptr <= w_ptr + 1'b1;
            if (last_word) begin
                word    <= '0;
                out_cnt <= out_cnt + 1'b1;
                busy    <= (out_cnt != last_out);
            end else begin
                word <= word + 1'b1;
            end
        end
    end

    assign w_addr   = w_ptr;
    assign a_addr   = a_base + lenet_pkg::sram_addr_t'(word);
    assign rd_valid = busy;
    assign rd_first = busy && (word == '0);
    assign rd_last  = busy && last_word;
    assign out_idx  = out_cnt;

endmodule

// ==== logic/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              compute_start,
    input  logic              layer_done,
    output logic              layer_start,
    output lenet_pkg::layer_t layer,
    output logic              compute_finish
);
    lenet_pkg::seq_state_t state;
    lenet_pkg::seq_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= lenet_pkg::idle;
            layer_start <= 1'b0;
        end else begin
            state       <= next_state;
            // Start pulse lands in the first run cycle
            layer_start <= (state == lenet_pkg::st_fc6) || (state == lenet_pkg::st_fc7);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lenet_pkg::idle: begin
                if (compute_start) begin
                    next_state = lenet_pkg::st_fc6;
                end
            end
            lenet_pkg::st_fc6: next_state = lenet_pkg::run_fc6;
            lenet_pkg::run_fc6: begin
                if (layer_done) begin
                    next_state = lenet_pkg::st_fc7;
                end
            end
            lenet_pkg::st_fc7: next_state = lenet_pkg::run_fc7;
            lenet_pkg::run_fc7: begin
                if (layer_done) begin
                    next_state = lenet_pkg::done;
                end
            end
            // Sticky until reset
            lenet_pkg::done: next_state = lenet_pkg::done;
            default: next_state = lenet_pkg::idle;
        endcase
    end

    always_comb begin
        case (state)
            lenet_pkg::st_fc7, lenet_pkg::run_fc7, lenet_pkg::done: layer = lenet_pkg::fc7;
            default: layer = lenet_pkg::fc6;
        endcase
    end

    assign compute_finish = (state == lenet_pkg::done);

endmodule

// ==== logic/lenet_pkg.sv ====
`include "lenet_consts.svh"

package lenet_pkg;

    typedef logic [`LENET_WORD_W-1:0] sram_word_t;
    typedef logic [`LENET_ADDR_W-1:0] sram_addr_t;
    typedef logic [`LENET_BE_W-1:0] byte_en_t;
    // Unsigned fixed point
    typedef logic [31:0] scale_t;
    typedef logic signed [31:0] acc_t;
    typedef logic signed [7:0] act_t;

    typedef enum logic {
        fc6,
        fc7
    } layer_t;

    typedef enum logic [2:0] {
        idle,
        st_fc6,
        run_fc6,
        st_fc7,
        run_fc7,
        done
    } seq_state_t;

    typedef struct packed {
        byte_en_t   wea;
        sram_addr_t addr;
        sram_word_t wdata;
    } sram_port_t;

endpackage

// ==== logic/lenet_consts.svh ====
`ifndef LENET_CONSTS_SVH
`define LENET_CONSTS_SVH

// SRAM geometry
`define LENET_WORD_W 32
`define LENET_ADDR_W 16
`define LENET_BE_W 4

// Layer sizes
`define LENET_FC6_IN 120
`define LENET_FC6_OUT 84
`define LENET_FC7_OUT 10

// Word bases in weight and activation SRAM
`define LENET_W_FC6_BASE 0
`define LENET_W_FC7_BASE 2520
`define LENET_A_IN_BASE 0
`define LENET_A_FC6_BASE 32
`define LENET_A_FC7_BASE 64

`define LENET_RQ_SHIFT 16

`endif
